//--- datapath.f
src/datapathPkg.sv
src/regFile.sv
src/busMux.sv
src/cpuRegs.sv
src/memInterface.sv
src/aluUnit.sv
src/datapath.sv
test/clockGen.sv
test/datapathTb.sv

//--- test/datapathTb.sv
`timescale 1ns/10ps
`default_nettype none

module datapathTb;

	localparam int testCycles = 200; // Rough length of all tests together.
	localparam int timeoutCycles = 10 * testCycles;

	logic clk;
	logic rstN;
	datapathPkg::ctrlT ctrl;
	datapathPkg::wordT mDataIn;
	datapathPkg::wordT inPort;
	datapathPkg::wordT busOut;
	datapathPkg::wordT memAddr;
	datapathPkg::wordT memDataOut;
	datapathPkg::wordT nextIn;
	datapathPkg::wordT nextMem;
	datapathPkg::wordT regModel [0:15];
	integer seed = 1390;
	int cycleCount = 0;

	clockGen i_clockGen (.clk(clk), .rstN(rstN));

	datapath i_dut (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.mDataIn(mDataIn),
		.inPort(inPort),
		.busOut(busOut),
		.memAddr(memAddr),
		.memDataOut(memDataOut)
	);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles.", timeoutCycles);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

	task automatic compareWord(input string name, input datapathPkg::wordT actual,
			input datapathPkg::wordT expected);
		if (actual !== expected) begin
			$display("Fail %s: actual %h expected %h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// Applies one control word at the rising edge; returns mid-cycle with the bus settled.
	task automatic drive(input datapathPkg::ctrlT c);
		@(posedge clk);
		ctrl <= c;
		inPort <= nextIn;
		mDataIn <= nextMem;
		@(negedge clk);
	endtask

	function automatic datapathPkg::ctrlT outCtrl(input datapathPkg::busSrcT src);
		datapathPkg::ctrlT c;
		c = '0;
		case (src)
			datapathPkg::srcHi: c.hiOut = 1'b1;
			datapathPkg::srcLo: c.loOut = 1'b1;
			datapathPkg::srcZHi: c.zHiOut = 1'b1;
			datapathPkg::srcZLo: c.zLoOut = 1'b1;
			datapathPkg::srcPc: c.pcOut = 1'b1;
			datapathPkg::srcMdr: c.mdrOut = 1'b1;
			datapathPkg::srcInPort: c.inPortOut = 1'b1;
			datapathPkg::srcNone: ;
			default: c.regOut[src[3:0]] = 1'b1;
		endcase
		return c;
	endfunction

	// Reference results built from the ALU rules, ZHi in the upper half.
	function automatic logic [63:0] aluModel(input datapathPkg::aluOpT op,
			input datapathPkg::wordT y, input datapathPkg::wordT b);
		logic [4:0] n;
		logic [63:0] r;
		logic signed [63:0] wideY;
		logic signed [63:0] wideB;
		n = b[4:0];
		r = '0;
		wideY = {{32{y[31]}}, y};
		wideB = {{32{b[31]}}, b};
		case (op)
			datapathPkg::opAdd: r[31:0] = y + b;
			datapathPkg::opSub: r[31:0] = y - b;
			datapathPkg::opAnd: r[31:0] = y & b;
			datapathPkg::opOr: r[31:0] = y | b;
			datapathPkg::opShr: r[31:0] = y >> n;
			datapathPkg::opShra: r[31:0] = wideY >> n; // Sign copies shift in from above.
			datapathPkg::opShl: r[31:0] = y << n;
			datapathPkg::opRor: r[31:0] = (n == 0) ? y : ((y >> n) | (y << (32 - n)));
			datapathPkg::opRol: r[31:0] = (n == 0) ? y : ((y << n) | (y >> (32 - n)));
			datapathPkg::opMul: r = wideY * wideB;
			datapathPkg::opDiv: begin
				if (b == '0) begin
					r = {y, 32'hFFFF_FFFF};
				end else begin
					r[31:0] = wideY / wideB;
					r[63:32] = wideY % wideB;
				end
			end
			datapathPkg::opNeg: r[31:0] = 32'd0 - b;
			datapathPkg::opNot: r[31:0] = ~b;
			datapathPkg::opIncPc: r[31:0] = b + 32'd1;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic checkReset();
		for (int s = 0; s < 23; s++) begin
			drive(outCtrl(datapathPkg::busSrcT'(5'(s))));
			compareWord($sformatf("busOut src %0d", s), busOut, '0);
		end
		drive(outCtrl(datapathPkg::srcNone));
		compareWord("busOut none", busOut, '0);
		compareWord("memAddr", memAddr, '0);
		compareWord("memDataOut", memDataOut, '0);
	endtask

	task automatic checkRegTransfer();
		datapathPkg::ctrlT c;
		for (int i = 0; i < 16; i++) begin
			regModel[i] = $random(seed);
			nextIn = regModel[i];
			c = outCtrl(datapathPkg::srcInPort);
			c.regIn[i] = 1'b1;
			drive(c);
		end
		for (int i = 0; i < 16; i++) begin
			drive(outCtrl(datapathPkg::busSrcT'(5'(i))));
			compareWord($sformatf("R%0d", i), busOut, regModel[i]);
		end
		c = outCtrl(datapathPkg::srcR3);
		c.regIn[7] = 1'b1;
		drive(c);
		regModel[7] = regModel[3];
		drive(outCtrl(datapathPkg::srcR7));
		compareWord("R7 copy", busOut, regModel[7]);
	endtask

	task automatic checkMemory();
		datapathPkg::ctrlT c;
		datapathPkg::wordT memWord;
		memWord = $random(seed);
		nextMem = memWord;
		c = '0;
		c.read = 1'b1;
		c.mdrIn = 1'b1;
		drive(c);
		nextMem = '0;
		drive(outCtrl(datapathPkg::srcMdr));
		compareWord("memDataOut read", memDataOut, memWord);
		compareWord("busOut MDR", busOut, memWord);
		nextIn = $random(seed);
		c = outCtrl(datapathPkg::srcInPort);
		c.mdrIn = 1'b1;
		drive(c);
		drive(outCtrl(datapathPkg::srcNone));
		compareWord("memDataOut bus", memDataOut, nextIn);
		c = outCtrl(datapathPkg::srcR5);
		c.marIn = 1'b1;
		drive(c);
		drive(outCtrl(datapathPkg::srcNone));
		compareWord("memAddr", memAddr, regModel[5]);
	endtask

	// Y from the input port, then the operation with the second operand on the bus.
	task automatic runAlu(input datapathPkg::aluOpT op, input datapathPkg::wordT y,
			input datapathPkg::wordT b, output logic [63:0] expected);
		datapathPkg::ctrlT c;
		expected = aluModel(op, y, b);
		nextIn = y;
		c = outCtrl(datapathPkg::srcInPort);
		c.yIn = 1'b1;
		drive(c);
		nextIn = b;
		c = outCtrl(datapathPkg::srcInPort);
		c.zIn = 1'b1;
		c.aluOp = op;
		drive(c);
		drive(outCtrl(datapathPkg::srcZLo));
		compareWord($sformatf("ZLo %s", op.name()), busOut, expected[31:0]);
		drive(outCtrl(datapathPkg::srcZHi));
		compareWord($sformatf("ZHi %s", op.name()), busOut, expected[63:32]);
	endtask

	task automatic checkWordOps();
		datapathPkg::aluOpT ops [0:10] = '{datapathPkg::opAdd, datapathPkg::opSub,
			datapathPkg::opAnd, datapathPkg::opOr, datapathPkg::opNeg, datapathPkg::opNot,
			datapathPkg::opShr, datapathPkg::opShra, datapathPkg::opShl,
			datapathPkg::opRor, datapathPkg::opRol};
		logic [63:0] result;
		for (int i = 0; i < 11; i++) begin
			runAlu(ops[i], $random(seed), $random(seed), result);
		end
	endtask

	task automatic moveToHiLo(input logic [63:0] expected);
		datapathPkg::ctrlT c;
		c = outCtrl(datapathPkg::srcZHi);
		c.hiIn = 1'b1;
		drive(c);
		c = outCtrl(datapathPkg::srcZLo);
		c.loIn = 1'b1;
		drive(c);
		drive(outCtrl(datapathPkg::srcHi));
		compareWord("HI", busOut, expected[63:32]);
		drive(outCtrl(datapathPkg::srcLo));
		compareWord("LO", busOut, expected[31:0]);
	endtask

	task automatic checkWideOps();
		logic [63:0] result;
		runAlu(datapathPkg::opMul, $random(seed), $random(seed), result);
		moveToHiLo(result);
		runAlu(datapathPkg::opDiv, $random(seed), $random(seed) >>> 20, result);
		moveToHiLo(result);
		runAlu(datapathPkg::opDiv, $random(seed), '0, result); // Divide by zero.
		moveToHiLo(result);
	endtask

	task automatic checkPcIncrement();
		datapathPkg::ctrlT c;
		datapathPkg::wordT startPc;
		startPc = $random(seed);
		nextIn = startPc;
		c = outCtrl(datapathPkg::srcInPort);
		c.pcIn = 1'b1;
		drive(c);
		repeat (3) begin
			c = outCtrl(datapathPkg::srcPc);
			c.aluOp = datapathPkg::opIncPc;
			c.zIn = 1'b1;
			drive(c);
			c = outCtrl(datapathPkg::srcZLo);
			c.pcIn = 1'b1;
			drive(c);
		end
		drive(outCtrl(datapathPkg::srcPc));
		compareWord("PC", busOut, startPc + 32'd3);
	endtask

	initial begin
		ctrl = '0;
		mDataIn = '0;
		inPort = '0;
		nextIn = '0;
		nextMem = '0;
		@(posedge rstN);
		checkReset();
		checkRegTransfer();
		checkMemory();
		checkWordOps();
		checkWideOps();
		checkPcIncrement();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod = 2; // 4 ns clock period.
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
	input logic clk,
	input logic rstN,
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT mDataIn,
	input datapathPkg::wordT inPort,
	output datapathPkg::wordT busOut,
	output datapathPkg::wordT memAddr,
	output datapathPkg::wordT memDataOut
);

	datapathPkg::wordT bus;
	datapathPkg::wordT regVals [0:15];
	datapathPkg::wordT pcVal;
	datapathPkg::wordT irVal; // Goes to the decode logic outside this block.
	datapathPkg::wordT hiVal;
	datapathPkg::wordT loVal;
	datapathPkg::wordT zHiVal;
	datapathPkg::wordT zLoVal;
	datapathPkg::wordT mdrVal;

	busMux i_busMux (
		.ctrl(ctrl),
		.regVals(regVals),
		.hiVal(hiVal),
		.loVal(loVal),
		.zHiVal(zHiVal),
		.zLoVal(zLoVal),
		.pcVal(pcVal),
		.mdrVal(mdrVal),
		.inPort(inPort),
		.bus(bus)
	);

	regFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.regVals(regVals)
	);

	cpuRegs i_cpuRegs (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.pcVal(pcVal),
		.irVal(irVal),
		.hiVal(hiVal),
		.loVal(loVal)
	);

	memInterface i_memInterface (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.mDataIn(mDataIn),
		.memAddr(memAddr),
		.mdrVal(mdrVal)
	);

	aluUnit i_aluUnit (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.zHiVal(zHiVal),
		.zLoVal(zLoVal)
	);

	assign busOut = bus;
	assign memDataOut = mdrVal;

endmodule

`default_nettype wire

//--- src/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
	input logic clk,
	input logic rstN,
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT bus,
	output datapathPkg::wordT zHiVal,
	output datapathPkg::wordT zLoVal
);

	datapathPkg::wordT yReg;
	logic [4:0] shiftAmt;
	logic [63:0] yPair;
	logic [63:0] rorPair;
	logic [63:0] rolPair;
	logic signed [63:0] product;
	logic signed [31:0] divisor;
	logic signed [31:0] quotient;
	logic signed [31:0] remainder;
	logic [63:0] aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			yReg <= '0;
		end else if (ctrl.yIn) begin
			yReg <= bus;
		end
	end

	always_comb begin
		shiftAmt = bus[4:0];
		yPair = {yReg, yReg};
		rorPair = yPair >> shiftAmt; // Low half holds the rotated word.
		rolPair = yPair << shiftAmt; // High half holds the rotated word.
	end

	always_comb begin
		product = $signed(yReg) * $signed(bus);
	end

	// A zero divisor is swapped for one so the divider never sees it.
	always_comb begin
		divisor = (bus == '0) ? 32'sd1 : $signed(bus);
		quotient = $signed(yReg) / divisor;
		remainder = $signed(yReg) % divisor;
	end

	always_comb begin
		aluResult = '0;
		case (ctrl.aluOp)
			datapathPkg::opAdd: aluResult[31:0] = yReg + bus;
			datapathPkg::opSub: aluResult[31:0] = yReg - bus;
			datapathPkg::opAnd: aluResult[31:0] = yReg & bus;
			datapathPkg::opOr: aluResult[31:0] = yReg | bus;
			datapathPkg::opShr: aluResult[31:0] = yReg >> shiftAmt;
			datapathPkg::opShra: aluResult[31:0] = $signed(yReg) >>> shiftAmt;
			datapathPkg::opShl: aluResult[31:0] = yReg << shiftAmt;
			datapathPkg::opRor: aluResult[31:0] = rorPair[31:0];
			datapathPkg::opRol: aluResult[31:0] = rolPair[63:32];
			datapathPkg::opMul: aluResult = product;
			datapathPkg::opDiv: begin
				if (bus == '0) begin
					aluResult = {yReg, 32'hFFFF_FFFF};
				end else begin
					aluResult = {remainder, quotient}; // Remainder goes to ZHi.
				end
			end
			datapathPkg::opNeg: aluResult[31:0] = -bus;
			datapathPkg::opNot: aluResult[31:0] = ~bus;
			datapathPkg::opIncPc: aluResult[31:0] = bus + 32'd1;
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			zHiVal <= '0;
			zLoVal <= '0;
		end else if (ctrl.zIn) begin
			zHiVal <= aluResult[63:32];
			zLoVal <= aluResult[31:0];
		end
	end

endmodule

`default_nettype wire

//--- src/memInterface.sv
`timescale 1ns/10ps
`default_nettype none

module memInterface (
	input logic clk,
	input logic rstN,
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT bus,
	input datapathPkg::wordT mDataIn,
	output datapathPkg::wordT memAddr,
	output datapathPkg::wordT mdrVal
);

	datapathPkg::wordT mdrNext;

	always_comb begin
		mdrNext = ctrl.read ? mDataIn : bus; // Read picks the memory side.
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memAddr <= '0;
		end else if (ctrl.marIn) begin
			memAddr <= bus;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mdrVal <= '0;
		end else if (ctrl.mdrIn) begin
			mdrVal <= mdrNext;
		end
	end

	// A read with no MDR load would drop the memory word.
	readNeedsMdr: assert property (
		@(posedge clk) disable iff (!rstN)
		ctrl.read |-> ctrl.mdrIn
	) else $error("memInterface: read without mdrIn");

endmodule

`default_nettype wire

//--- src/cpuRegs.sv
`timescale 1ns/10ps
`default_nettype none

module cpuRegs (
	input logic clk,
	input logic rstN,
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT bus,
	output datapathPkg::wordT pcVal,
	output datapathPkg::wordT irVal,
	output datapathPkg::wordT hiVal,
	output datapathPkg::wordT loVal
);

	// The PC increments by a trip through the ALU with opIncPc, then back in over the bus.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcVal <= '0;
		end else if (ctrl.pcIn) begin
			pcVal <= bus;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			irVal <= '0;
		end else if (ctrl.irIn) begin
			irVal <= bus; // Held for the decode logic.
		end
	end

	// HI and LO take the wide results after ZHi and ZLo are moved over.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hiVal <= '0;
			loVal <= '0;
		end else begin
			if (ctrl.hiIn) begin
				hiVal <= bus;
			end
			if (ctrl.loIn) begin
				loVal <= bus;
			end
		end
	end

	// A PC load from ZLo must follow a Z load; checks the increment sequence.
	pcFromZ: assert property (
		@(posedge clk) disable iff (!rstN)
		(ctrl.pcIn && ctrl.zLoOut) |-> $past(ctrl.zIn, 1) || $past(ctrl.zLoOut, 1)
	) else $error("cpuRegs: PC loaded from ZLo without a preceding Z load");

endmodule

`default_nettype wire

//--- src/busMux.sv
`timescale 1ns/10ps
`default_nettype none

module busMux (
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT regVals [0:15],
	input datapathPkg::wordT hiVal,
	input datapathPkg::wordT loVal,
	input datapathPkg::wordT zHiVal,
	input datapathPkg::wordT zLoVal,
	input datapathPkg::wordT pcVal,
	input datapathPkg::wordT mdrVal,
	input datapathPkg::wordT inPort,
	output datapathPkg::wordT bus
);

	logic [31:0] outStrobes;
	datapathPkg::busSrcT busSrc;

	// Bit positions follow the busSrcT codes.
	always_comb begin
		outStrobes = '0;
		outStrobes[15:0] = ctrl.regOut;
		outStrobes[16] = ctrl.hiOut;
		outStrobes[17] = ctrl.loOut;
		outStrobes[18] = ctrl.zHiOut;
		outStrobes[19] = ctrl.zLoOut;
		outStrobes[20] = ctrl.pcOut;
		outStrobes[21] = ctrl.mdrOut;
		outStrobes[22] = ctrl.inPortOut;
	end

	// 32-to-5 encoder.
	always_comb begin
		busSrc = datapathPkg::srcNone;
		for (int i = 0; i < 32; i++) begin
			if (outStrobes[i]) begin
				busSrc = datapathPkg::busSrcT'(5'(i));
			end
		end
	end

	always_comb begin
		case (busSrc)
			datapathPkg::srcHi: bus = hiVal;
			datapathPkg::srcLo: bus = loVal;
			datapathPkg::srcZHi: bus = zHiVal;
			datapathPkg::srcZLo: bus = zLoVal;
			datapathPkg::srcPc: bus = pcVal;
			datapathPkg::srcMdr: bus = mdrVal;
			datapathPkg::srcInPort: bus = inPort;
			datapathPkg::srcNone: bus = '0;
			default: begin
				if (busSrc <= datapathPkg::srcR15) begin
					bus = regVals[busSrc[3:0]];
				end else begin
					bus = '0;
				end
			end
		endcase
	end

	// Two drivers in one cycle would mean a sequencer fault upstream.
	always_comb begin
		if (!$isunknown(outStrobes)) begin
			singleDriver: assert final ($onehot0(outStrobes))
				else $error("busMux: more than one out strobe high");
		end
	end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk,
	input logic rstN,
	input datapathPkg::ctrlT ctrl,
	input datapathPkg::wordT bus,
	output datapathPkg::wordT regVals [0:15]
);

	datapathPkg::wordT regs [0:15];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (ctrl.regIn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			regVals[i] = regs[i];
		end
	end

	// The sequencer loads at most one general register per cycle.
	regInOneHot: assert property (
		@(posedge clk) disable iff (!rstN)
		$onehot0(ctrl.regIn)
	) else $error("regFile: more than one regIn strobe high");

endmodule

`default_nettype wire

//--- src/datapathPkg.sv
`default_nettype none

package datapathPkg;

	typedef logic [31:0] wordT;

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opShr,
		opShra,
		opShl,
		opRor,
		opRol,
		opMul,
		opDiv,
		opNeg,
		opNot,
		opIncPc // Bus plus one, Y is ignored.
	} aluOpT;

	// Codes 0 to 15 name R0 to R15 so the low bits index the register file.
	typedef enum logic [4:0] {
		srcR0, srcR1, srcR2, srcR3, srcR4, srcR5, srcR6, srcR7,
		srcR8, srcR9, srcR10, srcR11, srcR12, srcR13, srcR14, srcR15,
		srcHi,
		srcLo,
		srcZHi,
		srcZLo,
		srcPc,
		srcMdr,
		srcInPort,
		srcNone = 5'd31 // Bus reads zero.
	} busSrcT;

	typedef struct packed {
		logic [15:0] regIn;
		logic [15:0] regOut;
		logic pcIn;
		logic irIn;
		logic hiIn;
		logic loIn;
		logic yIn;
		logic zIn;
		logic marIn;
		logic mdrIn;
		logic read; // With mdrIn, MDR takes memory data instead of the bus.
		logic hiOut;
		logic loOut;
		logic zHiOut;
		logic zLoOut;
		logic pcOut;
		logic mdrOut;
		logic inPortOut;
		aluOpT aluOp;
	} ctrlT;

endpackage

`default_nettype wire
